// ==== include/gw_config.svh ====
`ifndef GW_CONFIG_SVH
`define GW_CONFIG_SVH

// Command and data path widths
`define GW_ADDR_WIDTH 16
`define GW_DATA_WIDTH 32

// Tag coordinate width
`define GW_CORD_WIDTH 7

// Address map, host MMIO sits below the DRAM base
`define GW_DRAM_BASE  16'h8000

// Host register file
`define GW_HOST_REGS  16
`define GW_FINISH_REG 15

// DRAM model depth in words
`define GW_DRAM_WORDS 256

`endif

// ==== logic/gw_tag_pkg.sv ====
`include "gw_config.svh"

package gw_tag_pkg;

  // Payload is a reset bit followed by the coordinate
  localparam int TAG_PAYLOAD_BITS = 1 + `GW_CORD_WIDTH;

  // Start bit and client index ahead of the payload
  localparam int TAG_FRAME_BITS = 2 + TAG_PAYLOAD_BITS;

  typedef enum logic {
    TAG_CLIENT_CORE = 1'b0,
    TAG_CLIENT_HOST = 1'b1
  } tag_client_e;

endpackage

// ==== logic/gw_mem_pkg.sv ====
`include "gw_config.svh"

package gw_mem_pkg;

  localparam int HOST_IDX_BITS  = $clog2(`GW_HOST_REGS);
  localparam int DRAM_WORD_BITS = `GW_ADDR_WIDTH - 1;

  // Host view of a command address
  typedef struct packed {
    logic                                     region;
    logic [`GW_ADDR_WIDTH-HOST_IDX_BITS-2:0]  pad;
    logic [HOST_IDX_BITS-1:0]                 reg_idx;
  } mem_host_view_s;

  // DRAM view, word address below the region bit
  typedef struct packed {
    logic                      region;
    logic [DRAM_WORD_BITS-1:0] word;
  } mem_dram_view_s;

  typedef union packed {
    mem_host_view_s host;
    mem_dram_view_s dram;
  } mem_addr_u;

  typedef enum logic [1:0] {
    SRC_HOST = 2'd0,
    SRC_DRAM = 2'd1,
    SRC_ERR  = 2'd2
  } resp_src_e;

endpackage

// ==== logic/gw_tag_master.sv ====
`timescale 1ns/1ps
`include "gw_config.svh"

module gw_tag_master (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      tag_en_i,
  input  logic                      tag_data_i,
  output logic                      core_reset_o,
  output logic                      host_reset_o,
  output logic [`GW_CORD_WIDTH-1:0] core_cord_o
);
  import gw_tag_pkg::*;

  localparam int cnt_width_lp = $clog2(TAG_FRAME_BITS);

  logic [cnt_width_lp-1:0]   bit_cnt_r;
  logic [TAG_FRAME_BITS-3:0] shift_r;
  logic [TAG_FRAME_BITS-2:0] frame;
  logic                      frame_done;
  tag_client_e               frame_client;

  ////////////////////////////////
  // Frame assembly
  ////////////////////////////////

  // Client index, reset bit, coordinate
  assign frame        = {shift_r, tag_data_i};
  assign frame_done   = tag_en_i && (bit_cnt_r == cnt_width_lp'(TAG_FRAME_BITS - 1));
  assign frame_client = tag_client_e'(frame[TAG_PAYLOAD_BITS]);

  // Zero count means idle, hunting for the start bit
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bit_cnt_r <= '0;
    end else if (tag_en_i) begin
      if (bit_cnt_r == '0) begin
        if (tag_data_i) begin
          bit_cnt_r <= cnt_width_lp'(1);
        end
      end else if (frame_done) begin
        bit_cnt_r <= '0;
      end else begin
        bit_cnt_r <= bit_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_en_i && (bit_cnt_r != '0)) begin
      shift_r <= frame[TAG_FRAME_BITS-3:0];
    end
  end

  ////////////////////////////////
  // Client registers
  ////////////////////////////////

  // Host coordinate is decoded but not kept
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      core_reset_o <= 1'b1;
      core_cord_o  <= '0;
      host_reset_o <= 1'b1;
    end else if (frame_done) begin
      case (frame_client)
        TAG_CLIENT_CORE: begin
          core_reset_o <= frame[TAG_PAYLOAD_BITS-1];
          core_cord_o  <= frame[`GW_CORD_WIDTH-1:0];
        end
        TAG_CLIENT_HOST: begin
          host_reset_o <= frame[TAG_PAYLOAD_BITS-1];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== logic/gw_mem_router.sv ====
`timescale 1ns/1ps
`include "gw_config.svh"

module gw_mem_router (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      core_reset_i,
  input  logic [`GW_CORD_WIDTH-1:0] core_cord_i,
  input  logic                      cmd_v_i,
  input  logic                      cmd_we_i,
  input  gw_mem_pkg::mem_addr_u     cmd_addr_i,
  input  logic [`GW_DATA_WIDTH-1:0] cmd_data_i,
  input  logic [`GW_CORD_WIDTH-1:0] cmd_cord_i,
  input  logic                      host_resp_v_i,
  input  logic [`GW_DATA_WIDTH-1:0] host_resp_data_i,
  input  logic                      dram_resp_v_i,
  input  logic [`GW_DATA_WIDTH-1:0] dram_resp_data_i,
  output logic                      cmd_yumi_o,
  output logic                      host_v_o,
  output logic                      dram_v_o,
  output logic                      tgt_we_o,
  output gw_mem_pkg::mem_addr_u     tgt_addr_o,
  output logic [`GW_DATA_WIDTH-1:0] tgt_data_o,
  output logic                      resp_v_o,
  output logic [`GW_DATA_WIDTH-1:0] resp_data_o,
  output logic                      resp_err_o
);
  import gw_mem_pkg::*;

  logic      req_outstanding_r;
  logic      err_v_r;
  logic      cord_ok;
  logic      host_not_dram;
  resp_src_e resp_src;

  assign cord_ok       = (cmd_cord_i == core_cord_i);
  assign host_not_dram = (cmd_addr_i < `GW_DRAM_BASE);

  // One request in flight at a time
  assign cmd_yumi_o = cmd_v_i & ~req_outstanding_r & ~core_reset_i;
  assign host_v_o   = cmd_yumi_o & cord_ok & host_not_dram;
  assign dram_v_o   = cmd_yumi_o & cord_ok & ~host_not_dram;
  assign tgt_we_o   = cmd_we_i;
  assign tgt_addr_o = cmd_addr_i;
  assign tgt_data_o = cmd_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || core_reset_i) begin
      req_outstanding_r <= 1'b0;
      err_v_r           <= 1'b0;
    end else begin
      err_v_r <= cmd_yumi_o & ~cord_ok;
      if (cmd_yumi_o) begin
        req_outstanding_r <= 1'b1;
      end else if (resp_v_o) begin
        req_outstanding_r <= 1'b0;
      end
    end
  end

  ////////////////////////////////
  // Response merge
  ////////////////////////////////

  always_comb begin
    if (host_resp_v_i) begin
      resp_src = SRC_HOST;
    end else if (dram_resp_v_i) begin
      resp_src = SRC_DRAM;
    end else begin
      resp_src = SRC_ERR;
    end
  end

  assign resp_v_o    = host_resp_v_i | dram_resp_v_i | err_v_r;
  assign resp_err_o  = err_v_r;
  assign resp_data_o = (resp_src == SRC_HOST) ? host_resp_data_i
                     : (resp_src == SRC_DRAM) ? dram_resp_data_i
                     : '0;

endmodule

// ==== logic/gw_host_mmio.sv ====
`timescale 1ns/1ps
`include "gw_config.svh"

module gw_host_mmio (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      host_reset_i,
  input  logic                      req_v_i,
  input  logic                      req_we_i,
  input  gw_mem_pkg::mem_addr_u     req_addr_i,
  input  logic [`GW_DATA_WIDTH-1:0] req_data_i,
  output logic                      resp_v_o,
  output logic [`GW_DATA_WIDTH-1:0] resp_data_o,
  output logic                      finish_o
);

  logic [`GW_DATA_WIDTH-1:0] regs_r [`GW_HOST_REGS];
  logic                      wr_en;

  assign wr_en = req_v_i & req_we_i & ~host_reset_i;

  // Register file, cleared by the host client
  always_ff @(posedge clk_i) begin
    if (host_reset_i) begin
      for (int i = 0; i < `GW_HOST_REGS; i++) begin
        regs_r[i] <= '0;
      end
    end else if (wr_en) begin
      regs_r[req_addr_i.host.reg_idx] <= req_data_i;
    end
  end

  // Program finish flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || host_reset_i) begin
      finish_o <= 1'b0;
    end else if (wr_en && (req_addr_i.host.reg_idx == `GW_FINISH_REG)) begin
      finish_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= req_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      resp_data_o <= req_we_i ? '0 : regs_r[req_addr_i.host.reg_idx];
    end
  end

endmodule

// ==== logic/gw_dram_model.sv ====
`timescale 1ns/1ps
`include "gw_config.svh"

module gw_dram_model (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      core_reset_i,
  input  logic                      req_v_i,
  input  logic                      req_we_i,
  input  gw_mem_pkg::mem_addr_u     req_addr_i,
  input  logic [`GW_DATA_WIDTH-1:0] req_data_i,
  output logic                      resp_v_o,
  output logic [`GW_DATA_WIDTH-1:0] resp_data_o
);

  localparam int idx_width_lp = $clog2(`GW_DRAM_WORDS);

  logic [`GW_DATA_WIDTH-1:0] mem_r [`GW_DRAM_WORDS];
  logic [idx_width_lp-1:0]   idx;
  logic                      s1_v_r;
  logic [`GW_DATA_WIDTH-1:0] s1_data_r;

  assign idx = req_addr_i.dram.word[idx_width_lp-1:0];

  // Stage 1, array access
  always_ff @(posedge clk_i) begin
    if (req_v_i && req_we_i) begin
      mem_r[idx] <= req_data_i;
    end
    if (req_v_i) begin
      s1_data_r <= req_we_i ? '0 : mem_r[idx];
    end
  end

  // Stage 2 holds the response
  always_ff @(posedge clk_i) begin
    resp_data_o <= s1_data_r;
  end

  // Valid bits of the pipe, flushed by the core client
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || core_reset_i) begin
      s1_v_r   <= 1'b0;
      resp_v_o <= 1'b0;
    end else begin
      s1_v_r   <= req_v_i;
      resp_v_o <= s1_v_r;
    end
  end

endmodule

// ==== logic/gw_bridge_top.sv ====
`timescale 1ns/1ps
`include "gw_config.svh"

module gw_bridge_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      tag_en_i,
  input  logic                      tag_data_i,
  input  logic                      cmd_v_i,
  input  logic                      cmd_we_i,
  input  gw_mem_pkg::mem_addr_u     cmd_addr_i,
  input  logic [`GW_DATA_WIDTH-1:0] cmd_data_i,
  input  logic [`GW_CORD_WIDTH-1:0] cmd_cord_i,
  output logic                      cmd_yumi_o,
  output logic                      resp_v_o,
  output logic [`GW_DATA_WIDTH-1:0] resp_data_o,
  output logic                      resp_err_o,
  output logic                      finish_o
);
  import gw_mem_pkg::*;

  logic                      core_reset_lo, host_reset_lo;
  logic [`GW_CORD_WIDTH-1:0] core_cord_lo;
  logic                      host_v_lo, dram_v_lo, tgt_we_lo;
  mem_addr_u                 tgt_addr_lo;
  logic [`GW_DATA_WIDTH-1:0] tgt_data_lo;
  logic                      host_resp_v_lo, dram_resp_v_lo;
  logic [`GW_DATA_WIDTH-1:0] host_resp_data_lo, dram_resp_data_lo;

  gw_tag_master tag_master
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
    ,.tag_en_i(tag_en_i), .tag_data_i(tag_data_i)
    ,.core_reset_o(core_reset_lo), .host_reset_o(host_reset_lo), .core_cord_o(core_cord_lo)
    );

  gw_mem_router router
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
    ,.core_reset_i(core_reset_lo), .core_cord_i(core_cord_lo)
    ,.cmd_v_i(cmd_v_i), .cmd_we_i(cmd_we_i), .cmd_addr_i(cmd_addr_i)
    ,.cmd_data_i(cmd_data_i), .cmd_cord_i(cmd_cord_i)
    ,.host_resp_v_i(host_resp_v_lo), .host_resp_data_i(host_resp_data_lo)
    ,.dram_resp_v_i(dram_resp_v_lo), .dram_resp_data_i(dram_resp_data_lo)
    ,.cmd_yumi_o(cmd_yumi_o), .host_v_o(host_v_lo), .dram_v_o(dram_v_lo)
    ,.tgt_we_o(tgt_we_lo), .tgt_addr_o(tgt_addr_lo), .tgt_data_o(tgt_data_lo)
    ,.resp_v_o(resp_v_o), .resp_data_o(resp_data_o), .resp_err_o(resp_err_o)
    );

  gw_host_mmio host_mmio
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .host_reset_i(host_reset_lo)
    ,.req_v_i(host_v_lo), .req_we_i(tgt_we_lo), .req_addr_i(tgt_addr_lo)
    ,.req_data_i(tgt_data_lo)
    ,.resp_v_o(host_resp_v_lo), .resp_data_o(host_resp_data_lo), .finish_o(finish_o)
    );

  gw_dram_model dram
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .core_reset_i(core_reset_lo)
    ,.req_v_i(dram_v_lo), .req_we_i(tgt_we_lo), .req_addr_i(tgt_addr_lo)
    ,.req_data_i(tgt_data_lo)
    ,.resp_v_o(dram_resp_v_lo), .resp_data_o(dram_resp_data_lo)
    );

endmodule

// ==== test/gw_clk_gen.sv ====
`timescale 1ns/1ps

module gw_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial clk_o = 1'b0;
  always #5 clk_o = ~clk_o;

  // Reset held over five rising edges, released mid-cycle
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== test/gw_checker.sv ====
`timescale 1ns/1ps
`include "gw_config.svh"

module gw_checker (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      cmd_yumi_i,
  input  logic                      resp_v_i,
  input  logic [`GW_DATA_WIDTH-1:0] resp_data_i,
  input  logic                      resp_err_i,
  output int                        err_cnt_o
);

  // Each entry is {latency, err, data}
  logic [`GW_DATA_WIDTH+2:0] exp_q [$];
  logic [`GW_DATA_WIDTH+2:0] cur_r;
  int                        wait_cnt = 0;
  int                        test_errs = 0;
  int                        tests_run = 0;
  int                        tests_bad = 0;
  string                     test_name = "reset";

  initial err_cnt_o = 0;

  task automatic expect_resp(input logic [`GW_DATA_WIDTH+2:0] result);
    exp_q.push_back(result);
  endtask

  task automatic note_error(input string what);
    $display("%s: %s", test_name, what);
    test_errs = test_errs + 1;
    err_cnt_o = err_cnt_o + 1;
  endtask

  task automatic compare_word(input string what, input logic [`GW_DATA_WIDTH-1:0] exp,
                              input logic [`GW_DATA_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
      test_errs = test_errs + 1;
      err_cnt_o = err_cnt_o + 1;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run = tests_run + 1;
    if (test_errs != 0) begin
      tests_bad = tests_bad + 1;
    end
    $display("%-30s %0d errors", test_name, test_errs);
  endtask

  task automatic print_counts();
    $display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, err_cnt_o);
  endtask

  ////////////////////////////////
  // Response tracking
  ////////////////////////////////

  // Countdown from the yumi edge to the edge that must carry the response
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      // Next yumi only in the cycle after the response
      if (cmd_yumi_i && wait_cnt > 0) begin
        note_error("unexpected yumi while a request is outstanding");
      end
      if (wait_cnt > 0) begin
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0 && !resp_v_i) begin
          note_error("missing response");
        end else if (wait_cnt == 0) begin
          compare_word("resp_data", cur_r[`GW_DATA_WIDTH-1:0], resp_data_i);
          compare_word("resp_err", cur_r[`GW_DATA_WIDTH], resp_err_i);
        end else if (resp_v_i) begin
          note_error("response arrived early");
        end
      end else if (resp_v_i) begin
        note_error("unexpected response");
      end
      if (cmd_yumi_i && exp_q.size() == 0) begin
        note_error("yumi without a queued command");
      end else if (cmd_yumi_i && wait_cnt == 0) begin
        cur_r = exp_q.pop_front();
        wait_cnt = cur_r[`GW_DATA_WIDTH+2:`GW_DATA_WIDTH+1];
      end
    end
  end

endmodule

// ==== test/gw_tb.sv ====
`timescale 1ns/1ps
`include "gw_config.svh"

module gw_tb;
  import gw_tag_pkg::*;
  import gw_mem_pkg::*;

  localparam int num_cmds    = 24;
  localparam int num_frames  = 4;
  localparam int cycle_limit = num_cmds * 40 + num_frames * 20 + 100;

  logic                      clk, rst_n;
  logic                      tag_en, tag_data;
  logic                      cmd_v, cmd_we, cmd_yumi;
  mem_addr_u                 cmd_addr;
  logic [`GW_DATA_WIDTH-1:0] cmd_data, resp_data;
  logic [`GW_CORD_WIDTH-1:0] cmd_cord;
  logic                      resp_v, resp_err, finish;
  int                        err_cnt;

  logic [`GW_DATA_WIDTH-1:0] host_model [`GW_HOST_REGS];
  logic [`GW_DATA_WIDTH-1:0] dram_model [`GW_DRAM_WORDS];
  logic [`GW_CORD_WIDTH-1:0] model_cord = '0;
  logic [`GW_ADDR_WIDTH-1:0] dram_addrs [4];
  integer                    seed = 32'h2292_3b3e;
  int                        cycles = 0;

  gw_clk_gen CLK (.clk_o(clk), .rst_n_o(rst_n));

  gw_bridge_top DUT
    (.clk_i(clk), .rst_n_i(rst_n), .tag_en_i(tag_en), .tag_data_i(tag_data)
    ,.cmd_v_i(cmd_v), .cmd_we_i(cmd_we), .cmd_addr_i(cmd_addr)
    ,.cmd_data_i(cmd_data), .cmd_cord_i(cmd_cord), .cmd_yumi_o(cmd_yumi)
    ,.resp_v_o(resp_v), .resp_data_o(resp_data), .resp_err_o(resp_err), .finish_o(finish)
    );

  gw_checker CHK
    (.clk_i(clk), .rst_n_i(rst_n), .cmd_yumi_i(cmd_yumi), .resp_v_i(resp_v)
    ,.resp_data_i(resp_data), .resp_err_i(resp_err), .err_cnt_o(err_cnt)
    );

  // Expected {latency, err, data} of an accepted command, models updated on the way
  function automatic logic [`GW_DATA_WIDTH+2:0] ref_result(input logic we,
      input logic [`GW_ADDR_WIDTH-1:0] addr, input logic [`GW_DATA_WIDTH-1:0] data,
      input logic [`GW_CORD_WIDTH-1:0] cord);
    logic [`GW_DATA_WIDTH-1:0] rd;
    resp_src_e                 src;
    rd = '0;
    if (cord != model_cord) begin
      src = SRC_ERR;
    end else if (addr < `GW_DRAM_BASE) begin
      src = SRC_HOST;
      if (we) begin
        host_model[addr[3:0]] = data;
      end else begin
        rd = host_model[addr[3:0]];
      end
    end else begin
      src = SRC_DRAM;
      if (we) begin
        dram_model[addr[7:0]] = data;
      end else begin
        rd = dram_model[addr[7:0]];
      end
    end
    return {(src == SRC_DRAM) ? 2'd2 : 2'd1, src == SRC_ERR, rd};
  endfunction

  ////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////

  task automatic send_frame(input tag_client_e client, input logic rst,
                            input logic [`GW_CORD_WIDTH-1:0] cord);
    logic [TAG_FRAME_BITS-1:0] frame;
    frame = {1'b1, client, rst, cord};
    for (int i = TAG_FRAME_BITS - 1; i >= 0; i--) begin
      @(negedge clk);
      tag_en   = 1'b1;
      tag_data = frame[i];
    end
    @(negedge clk);
    tag_en = 1'b0;
    if (client == TAG_CLIENT_CORE) begin
      model_cord = cord;
    end else if (rst) begin
      foreach (host_model[i]) begin
        host_model[i] = '0;
      end
    end
  endtask

  task automatic drive_cmd(input logic we, input logic [`GW_ADDR_WIDTH-1:0] addr,
                           input logic [`GW_DATA_WIDTH-1:0] data,
                           input logic [`GW_CORD_WIDTH-1:0] cord);
    cmd_v    = 1'b1;
    cmd_we   = we;
    cmd_addr = addr;
    cmd_data = data;
    cmd_cord = cord;
  endtask

  task automatic wait_yumi(input int limit);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!cmd_yumi && n < limit);
    if (!cmd_yumi) begin
      CHK.note_error("no yumi for a valid command");
    end
  endtask

  // Ends mid-cycle so the checker has seen the response edge
  task automatic wait_resp();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!resp_v && n < 4);
    @(negedge clk);
  endtask

  task automatic present_cmd(input logic we, input logic [`GW_ADDR_WIDTH-1:0] addr,
                             input logic [`GW_DATA_WIDTH-1:0] data,
                             input logic [`GW_CORD_WIDTH-1:0] cord);
    @(negedge clk);
    drive_cmd(we, addr, data, cord);
    CHK.expect_resp(ref_result(we, addr, data, cord));
    wait_yumi(20);
  endtask

  task automatic run_cmd(input logic we, input logic [`GW_ADDR_WIDTH-1:0] addr,
                         input logic [`GW_DATA_WIDTH-1:0] data,
                         input logic [`GW_CORD_WIDTH-1:0] cord);
    present_cmd(we, addr, data, cord);
    @(negedge clk);
    cmd_v = 1'b0;
    wait_resp();
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////
  // Tests
  ////////////////////////////////

  initial begin
    tag_en   = 1'b0;
    tag_data = 1'b0;
    cmd_v    = 1'b0;
    cmd_we   = 1'b0;
    cmd_addr = '0;
    cmd_data = '0;
    cmd_cord = '0;
    foreach (host_model[i]) begin
      host_model[i] = '0;
    end
    wait (rst_n === 1'b1);

    CHK.start_test("yumi gated by core client");
    @(negedge clk);
    drive_cmd(1'b1, 16'hff00, $random(seed), 7'd5);
    repeat (20) begin
      @(posedge clk);
      if (cmd_yumi) begin
        CHK.note_error("yumi before the core client left reset");
      end
    end
    send_frame(TAG_CLIENT_CORE, 1'b0, 7'd5);
    CHK.expect_resp(ref_result(cmd_we, cmd_addr, cmd_data, cmd_cord));
    wait_yumi(2);
    @(negedge clk);
    cmd_v = 1'b0;
    wait_resp();
    CHK.end_test();

    CHK.start_test("dram write and read");
    for (int i = 0; i < 4; i++) begin
      dram_addrs[i] = `GW_DRAM_BASE | 16'($random(seed));
      run_cmd(1'b1, dram_addrs[i], $random(seed), 7'd5);
    end
    for (int i = 0; i < 4; i++) begin
      run_cmd(1'b0, dram_addrs[i], '0, 7'd5);
    end
    CHK.end_test();

    CHK.start_test("host register write and read");
    send_frame(TAG_CLIENT_HOST, 1'b0, 7'd0);
    run_cmd(1'b1, 16'h0002, $random(seed), 7'd5);
    run_cmd(1'b1, 16'h3a49, $random(seed), 7'd5);
    CHK.compare_word("finish_o", 32'd0, finish);
    run_cmd(1'b1, 16'h7fff, $random(seed), 7'd5);
    CHK.compare_word("finish_o", 32'd1, finish);
    run_cmd(1'b0, 16'h0002, '0, 7'd5);
    run_cmd(1'b0, 16'h3a49, '0, 7'd5);
    run_cmd(1'b0, 16'h7fff, '0, 7'd5);
    CHK.end_test();

    CHK.start_test("coordinate mismatch");
    run_cmd(1'b1, 16'h0002, 32'hdead_beef, 7'd6);
    run_cmd(1'b0, 16'h0002, '0, 7'd5);
    run_cmd(1'b1, dram_addrs[0], 32'hdead_beef, 7'd4);
    run_cmd(1'b0, dram_addrs[0], '0, 7'd5);
    CHK.end_test();

    CHK.start_test("host client reset");
    send_frame(TAG_CLIENT_HOST, 1'b1, 7'd0);
    send_frame(TAG_CLIENT_HOST, 1'b0, 7'd0);
    CHK.compare_word("finish_o", 32'd0, finish);
    run_cmd(1'b0, 16'h0002, '0, 7'd5);
    run_cmd(1'b0, 16'h7fff, '0, 7'd5);
    run_cmd(1'b0, dram_addrs[1], '0, 7'd5);
    CHK.end_test();

    // Second command stays valid behind the first
    CHK.start_test("back to back commands");
    present_cmd(1'b0, dram_addrs[2], '0, 7'd5);
    present_cmd(1'b1, 16'h0005, 32'h1234_5678, 7'd5);
    @(negedge clk);
    cmd_v = 1'b0;
    wait_resp();
    CHK.end_test();

    CHK.print_counts();
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
logic/gw_tag_pkg.sv
logic/gw_mem_pkg.sv
logic/gw_tag_master.sv
logic/gw_mem_router.sv
logic/gw_host_mmio.sv
logic/gw_dram_model.sv
logic/gw_bridge_top.sv
test/gw_clk_gen.sv
test/gw_checker.sv
test/gw_tb.sv

// ==== Bender.yml ====
package:
  name: gw_bridge

sources:
  - include_dirs:
      - include
    files:
      - logic/gw_tag_pkg.sv
      - logic/gw_mem_pkg.sv
      - logic/gw_tag_master.sv
      - logic/gw_mem_router.sv
      - logic/gw_host_mmio.sv
      - logic/gw_dram_model.sv
      - logic/gw_bridge_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/gw_clk_gen.sv
      - test/gw_checker.sv
      - test/gw_tb.sv
